// ==== hdl/immGen.sv ====
`timescale 1ns/1ps
`include "rdWb_consts.svh"

module immGen import rdWbPkg::*; (
    input  instrT instr,
    output xlenT  imm
);

    logic sgn;

    assign sgn = instr[31];

    always_comb begin
        case (instr[6:0])
            `OP_LOAD, `OP_IMM, `OP_IMMW, `OP_JALR: begin   // I
                imm = {{(`XLEN-12){sgn}}, instr[31:20]};
            end
            `OP_STORE: begin                               // S
                imm = {{(`XLEN-12){sgn}}, instr[31:25], instr[11:7]};
            end
            `OP_BRANCH: begin                              // B
                imm = {{(`XLEN-12){sgn}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            `OP_LUI, `OP_AUIPC: begin                      // U
                imm = {{(`XLEN-32){sgn}}, instr[31:12], 12'b0};
            end
            `OP_JAL: begin                                 // J
                imm = {{(`XLEN-20){sgn}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`include "rdWb_consts.svh"

module instrDecoder import rdWbPkg::*; (
    input  logic    enable,
    input  instrT   instr,
    output decCtrlT ctrl,
    output xlenT    imm,
    output logic    jump,
    output logic    branch
);

    decCtrlT    dec;
    xlenT       immRaw;
    logic       jmp;
    logic       br;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    immGen immGen (
        .instr(instr),
        .imm  (immRaw)
    );

    always_comb begin
        dec = '0;
        jmp = 1'b0;
        br  = 1'b0;
        case (instr[6:0])
            `OP_LOAD: begin
                dec.regWrite  = 1'b1;
                dec.resultSrc = `RES_MEM;
                dec.memSize   = {`MEM_READ, funct3};
                dec.aluSrc    = 1'b1;
                dec.rs1       = instr[19:15];
                dec.rd        = instr[11:7];
                dec.aluCtrl   = `ALU_ADD;   // address calc
            end
            `OP_STORE: begin
                dec.memSize = {`MEM_WRITE, funct3};
                dec.aluSrc  = 1'b1;
                dec.rs1     = instr[19:15];
                dec.rs2     = instr[24:20];
                dec.aluCtrl = `ALU_ADD;
            end
            `OP_IMM, `OP_IMMW: begin
                dec.regWrite = 1'b1;
                dec.aluSrc   = 1'b1;
                dec.rs1      = instr[19:15];
                dec.rd       = instr[11:7];
                if (instr[3]) begin         // word forms
                    case (funct3)
                        3'b000: dec.aluCtrl = `ALU_ADDW;
                        3'b001: dec.aluCtrl = `ALU_SLLW;
                        3'b101: dec.aluCtrl = instr[30] ? `ALU_SRAW : `ALU_SRLW;
                        default: dec.aluCtrl = '0;
                    endcase
                end else begin
                    case (funct3)
                        3'b000: dec.aluCtrl = `ALU_ADD;
                        3'b001: dec.aluCtrl = `ALU_SLL;
                        3'b010: dec.aluCtrl = `ALU_SLT;
                        3'b011: dec.aluCtrl = `ALU_SLTU;
                        3'b100: dec.aluCtrl = `ALU_XOR;
                        3'b101: dec.aluCtrl = instr[30] ? `ALU_SRA : `ALU_SRL;
                        3'b110: dec.aluCtrl = `ALU_OR;
                        default: dec.aluCtrl = `ALU_AND;
                    endcase
                end
            end
            `OP_REG: begin
                dec.regWrite = 1'b1;
                dec.rs1      = instr[19:15];
                dec.rs2      = instr[24:20];
                dec.rd       = instr[11:7];
                case ({funct7, funct3})
                    {`F7_BASE, 3'b000}:   dec.aluCtrl = `ALU_ADD;
                    {`F7_BASE, 3'b001}:   dec.aluCtrl = `ALU_SLL;
                    {`F7_BASE, 3'b010}:   dec.aluCtrl = `ALU_SLT;
                    {`F7_BASE, 3'b011}:   dec.aluCtrl = `ALU_SLTU;
                    {`F7_BASE, 3'b100}:   dec.aluCtrl = `ALU_XOR;
                    {`F7_BASE, 3'b101}:   dec.aluCtrl = `ALU_SRL;
                    {`F7_BASE, 3'b110}:   dec.aluCtrl = `ALU_OR;
                    {`F7_BASE, 3'b111}:   dec.aluCtrl = `ALU_AND;
                    {`F7_ALT, 3'b000}:    dec.aluCtrl = `ALU_SUB;
                    {`F7_ALT, 3'b101}:    dec.aluCtrl = `ALU_SRA;
                    {`F7_MULDIV, 3'b000}: dec.aluCtrl = `ALU_MUL;
                    {`F7_MULDIV, 3'b001}: dec.aluCtrl = `ALU_MULH;
                    {`F7_MULDIV, 3'b010}: dec.aluCtrl = `ALU_MULHSU;
                    {`F7_MULDIV, 3'b011}: dec.aluCtrl = `ALU_MULHU;
                    {`F7_MULDIV, 3'b100}: dec.aluCtrl = `ALU_DIV;
                    {`F7_MULDIV, 3'b101}: dec.aluCtrl = `ALU_DIVU;
                    {`F7_MULDIV, 3'b110}: dec.aluCtrl = `ALU_REM;
                    {`F7_MULDIV, 3'b111}: dec.aluCtrl = `ALU_REMU;
                    default:              dec.aluCtrl = '0;
                endcase
            end
            `OP_REGW: begin
                dec.regWrite = 1'b1;
                dec.rs1      = instr[19:15];
                dec.rs2      = instr[24:20];
                dec.rd       = instr[11:7];
                case ({funct7, funct3})
                    {`F7_BASE, 3'b000}:   dec.aluCtrl = `ALU_ADDW;
                    {`F7_BASE, 3'b001}:   dec.aluCtrl = `ALU_SLLW;
                    {`F7_BASE, 3'b101}:   dec.aluCtrl = `ALU_SRLW;
                    {`F7_ALT, 3'b000}:    dec.aluCtrl = `ALU_SUBW;
                    {`F7_ALT, 3'b101}:    dec.aluCtrl = `ALU_SRAW;
                    {`F7_MULDIV, 3'b000}: dec.aluCtrl = `ALU_MULW;
                    {`F7_MULDIV, 3'b100}: dec.aluCtrl = `ALU_DIVW;
                    {`F7_MULDIV, 3'b101}: dec.aluCtrl = `ALU_DIVUW;
                    {`F7_MULDIV, 3'b110}: dec.aluCtrl = `ALU_REMW;
                    {`F7_MULDIV, 3'b111}: dec.aluCtrl = `ALU_REMUW;
                    default:              dec.aluCtrl = '0;
                endcase
            end
            `OP_LUI, `OP_AUIPC: begin
                dec.regWrite = 1'b1;
                dec.aluSrc   = 1'b1;
                dec.rd       = instr[11:7];
                dec.aluCtrl  = instr[5] ? `ALU_LUI : `ALU_AUIPC;
            end
            `OP_BRANCH: begin
                br      = 1'b1;
                dec.rs1 = instr[19:15];
                dec.rs2 = instr[24:20];
                case (funct3)
                    3'b000: dec.aluCtrl = `ALU_BEQ;
                    3'b001: dec.aluCtrl = `ALU_BNE;
                    3'b100: dec.aluCtrl = `ALU_BLT;
                    3'b101: dec.aluCtrl = `ALU_BGE;
                    3'b110: dec.aluCtrl = `ALU_BLTU;
                    3'b111: dec.aluCtrl = `ALU_BGEU;
                    default: dec.aluCtrl = '0;
                endcase
            end
            `OP_JALR, `OP_JAL: begin
                jmp           = 1'b1;
                dec.regWrite  = 1'b1;
                dec.resultSrc = `RES_PC4;   // link address
                dec.aluSrc    = 1'b1;
                dec.rd        = instr[11:7];
                if (instr[3]) begin
                    dec.aluCtrl = `ALU_JAL;
                end else begin
                    dec.rs1     = instr[19:15];
                    dec.aluCtrl = `ALU_JALR;
                end
            end
            `OP_SYSTEM: begin
                // only ecall, all other system encodings stay zero
                if (funct3 == 3'b000 && instr[31:20] == 12'h000) begin
                    dec.ecall   = 1'b1;
                    dec.aluCtrl = `ALU_ECALL;
                end
            end
            default: dec = '0;
        endcase
    end

    // stalled lane looks like a bubble
    assign ctrl   = enable ? dec : '0;
    assign imm    = enable ? immRaw : '0;
    assign jump   = enable & jmp;
    assign branch = enable & br;

endmodule

// ==== hdl/rdWb.sv ====
`timescale 1ns/1ps

module rdWb import rdWbPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     enableD,
    input  instrT    instrD1,
    input  instrT    instrD2,
    output decCtrlT  ctrlD1,
    output decCtrlT  ctrlD2,
    output xlenT     immD1,
    output xlenT     immD2,
    output operandsT opsD1,
    output operandsT opsD2,
    output logic     jumpD,
    output logic     branchD,
    input  logic     enableW,
    input  wbReqT    wbW1,
    input  wbReqT    wbW2
);

    logic jump1;
    logic jump2;
    logic branch1;
    logic branch2;

    instrDecoder lane1 (
        .enable(enableD),
        .instr (instrD1),
        .ctrl  (ctrlD1),
        .imm   (immD1),
        .jump  (jump1),
        .branch(branch1)
    );

    instrDecoder lane2 (
        .enable(enableD),
        .instr (instrD2),
        .ctrl  (ctrlD2),
        .imm   (immD2),
        .jump  (jump2),
        .branch(branch2)
    );

    // unused sources decode to x0, reading zero
    regFile regFile (
        .clk    (clk),
        .arstN  (arstN),
        .wrEn   (enableW),
        .wb1    (wbW1),
        .wb2    (wbW2),
        .rdIdx1A(ctrlD1.rs1),
        .rdIdx1B(ctrlD1.rs2),
        .rdIdx2A(ctrlD2.rs1),
        .rdIdx2B(ctrlD2.rs2),
        .ops1   (opsD1),
        .ops2   (opsD2)
    );

    assign jumpD   = jump1 | jump2;     // shared by both lanes
    assign branchD = branch1 | branch2;

endmodule

// ==== hdl/rdWbPkg.sv ====
`include "rdWb_consts.svh"

package rdWbPkg;

    typedef logic [`XLEN-1:0] xlenT;      // data word
    typedef logic [31:0]      instrT;     // instruction word
    typedef logic [4:0]       regIdxT;    // register index
    typedef logic [5:0]       aluCtrlT;   // alu operation code
    typedef logic [1:0]       resultSrcT; // 0 alu, 1 mem, 2 pc+4
    typedef logic [4:0]       memSizeT;   // {direction, funct3}

    // decoded control of one lane
    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        memSizeT   memSize;
        aluCtrlT   aluCtrl;
        logic      aluSrc;    // immediate as operand b
        regIdxT    rs1;
        regIdxT    rs2;
        regIdxT    rd;
        logic      ecall;
    } decCtrlT;

    // register file read data of one lane
    typedef struct packed {
        xlenT rs1Data;
        xlenT rs2Data;
    } operandsT;

    // write-back request of one lane
    typedef struct packed {
        logic   regWrite;
        regIdxT rd;
        xlenT   result;
    } wbReqT;

endpackage

// ==== hdl/rdWb_consts.svh ====
`ifndef RDWB_CONSTS_SVH
`define RDWB_CONSTS_SVH

`define XLEN  64
`define NREGS 32

`define OP_LOAD   7'b0000011
`define OP_IMM    7'b0010011
`define OP_AUIPC  7'b0010111
`define OP_IMMW   7'b0011011
`define OP_STORE  7'b0100011
`define OP_REG    7'b0110011
`define OP_LUI    7'b0110111
`define OP_REGW   7'b0111011
`define OP_BRANCH 7'b1100011
`define OP_JALR   7'b1100111
`define OP_JAL    7'b1101111
`define OP_SYSTEM 7'b1110011

// funct7 groups
`define F7_BASE   7'b0000000
`define F7_MULDIV 7'b0000001
`define F7_ALT    7'b0100000

// result select
`define RES_ALU 2'd0
`define RES_MEM 2'd1
`define RES_PC4 2'd2

// upper bits of memSize
`define MEM_READ  2'b01
`define MEM_WRITE 2'b10

`define ALU_SLL    6'd1
`define ALU_SRL    6'd2
`define ALU_SRA    6'd3
`define ALU_ADD    6'd4
`define ALU_SUB    6'd5
`define ALU_DIV    6'd6
`define ALU_DIVU   6'd7
`define ALU_REM    6'd8
`define ALU_REMU   6'd9
`define ALU_MUL    6'd10
`define ALU_MULH   6'd11
`define ALU_MULHU  6'd12
`define ALU_MULHSU 6'd13
`define ALU_XOR    6'd14
`define ALU_OR     6'd15
`define ALU_AND    6'd16
`define ALU_SLT    6'd17
`define ALU_SLTU   6'd18
`define ALU_AUIPC  6'd19
`define ALU_LUI    6'd20
`define ALU_JALR   6'd21
`define ALU_JAL    6'd22
`define ALU_BEQ    6'd23
`define ALU_BNE    6'd24
`define ALU_BLT    6'd25
`define ALU_BGE    6'd26
`define ALU_BLTU   6'd27
`define ALU_BGEU   6'd28
`define ALU_ECALL  6'd29
`define ALU_SLLW   6'd33
`define ALU_SRLW   6'd34
`define ALU_SRAW   6'd35
`define ALU_ADDW   6'd36
`define ALU_SUBW   6'd37
`define ALU_DIVW   6'd38
`define ALU_DIVUW  6'd39
`define ALU_REMW   6'd40
`define ALU_REMUW  6'd41
`define ALU_MULW   6'd42

`endif

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rdWb_consts.svh"

module regFile import rdWbPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     wrEn,
    input  wbReqT    wb1,
    input  wbReqT    wb2,
    input  regIdxT   rdIdx1A,
    input  regIdxT   rdIdx1B,
    input  regIdxT   rdIdx2A,
    input  regIdxT   rdIdx2B,
    output operandsT ops1,
    output operandsT ops2
);

    xlenT regs [`NREGS];
    logic wr1;
    logic wr2;
    logic lane2Wins;

    assign wr2       = wrEn & wb2.regWrite & (wb2.rd != '0);
    assign lane2Wins = wb2.regWrite & (wb2.rd == wb1.rd);   // same rd, lane 2 kept
    assign wr1       = wrEn & wb1.regWrite & (wb1.rd != '0) & ~lane2Wins;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr1) begin
                regs[wb1.rd] <= wb1.result;
            end
            if (wr2) begin
                regs[wb2.rd] <= wb2.result;
            end
        end
    end

    // x0 never written so it reads zero
    assign ops1.rs1Data = regs[rdIdx1A];
    assign ops1.rs2Data = regs[rdIdx1B];
    assign ops2.rs1Data = regs[rdIdx2A];
    assign ops2.rs2Data = regs[rdIdx2B];

endmodule

// ==== rdWb.f ====
+incdir+hdl
hdl/rdWbPkg.sv
hdl/immGen.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/rdWb.sv
tests/rdWb_chk.sv
tests/rdWbTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the rdWb testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f rdWb.f --top-module rdWbTb -Mdir obj_dir -o rdWbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the summary is printed
./obj_dir/rdWbSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tests/rdWbTb.sv ====
`timescale 1ns/1ps
`include "rdWb_consts.svh"

module rdWbTb import rdWbPkg::*; ();

    localparam int    CYCLE_LIMIT = 400;   // tests need about 180 cycles
    localparam instrT NOP   = 32'h0000_0013;
    localparam instrT ECALL = 32'h0000_0073;

    logic     clk = 1'b0;
    logic     arstN;
    logic     enableD;
    instrT    instrD1;
    instrT    instrD2;
    decCtrlT  ctrlD1;
    decCtrlT  ctrlD2;
    xlenT     immD1;
    xlenT     immD2;
    operandsT opsD1;
    operandsT opsD2;
    logic     jumpD;
    logic     branchD;
    logic     enableW;
    wbReqT    wbW1;
    wbReqT    wbW2;
    int       seed = 17;
    int       cycles = 0;
    int       testsRun = 0;
    int       testsFailed = 0;
    int       failsBefore = 0;

    rdWb DUT (.*);

    bind rdWb rdWbChk chk (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic regIdxT randReg();
        return regIdxT'($random(seed));
    endfunction

    function automatic xlenT randData();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic instrT addInstr(regIdxT rs1, regIdxT rs2);
        return {`F7_BASE, rs2, rs1, 3'b000, 5'd3, `OP_REG};
    endfunction

    // kinds 0..6 are add, sub, addi, ld, sd, lui, beq
    function automatic instrT randInstr(int kind);
        logic [11:0] imm12;
        imm12 = 12'($random(seed));
        case (kind)
            0:       return {`F7_BASE, randReg(), randReg(), 3'b000, randReg(), `OP_REG};
            1:       return {`F7_ALT, randReg(), randReg(), 3'b000, randReg(), `OP_REG};
            2:       return {imm12, randReg(), 3'b000, randReg(), `OP_IMM};
            3:       return {imm12, randReg(), 3'b011, randReg(), `OP_LOAD};
            4:       return {imm12[11:5], randReg(), randReg(), 3'b011, imm12[4:0], `OP_STORE};
            5:       return {20'($random(seed)), randReg(), `OP_LUI};
            default: return {imm12[11:5], randReg(), randReg(), 3'b000, imm12[4:0], `OP_BRANCH};
        endcase
    endfunction

    task automatic decode(logic en, instrT i1, instrT i2);
        @(posedge clk);
        enableD <= en;
        instrD1 <= i1;
        instrD2 <= i2;
        enableW <= 1'b0;
    endtask

    task automatic writeRegs(wbReqT w1, wbReqT w2);
        @(posedge clk);
        enableD <= 1'b0;
        enableW <= 1'b1;
        wbW1    <= w1;
        wbW2    <= w2;
    endtask

    task automatic endTest(string name);
        int    fails;
        string verdict;
        @(posedge clk);   // last drive is sampled here
        #1;
        fails       = DUT.chk.failCount - failsBefore;
        failsBefore = DUT.chk.failCount;
        verdict     = (fails == 0) ? "passed" : "FAILED";
        testsRun++;
        if (fails != 0) begin
            testsFailed++;
        end
        $display("test %s %s, %0d assertion failures", name, verdict, fails);
    endtask

    initial begin
        wbReqT  w1;
        wbReqT  w2;
        regIdxT r;
        arstN   = 1'b0;
        enableD = 1'b0;
        instrD1 = '0;
        instrD2 = '0;
        enableW = 1'b0;
        wbW1    = '0;
        wbW2    = '0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        repeat (8) decode(1'b1, randInstr(0), randInstr(1));
        endTest("resetRead");

        repeat (24) begin
            r  = randReg();
            w1 = {1'b1, r, randData()};
            w2 = {1'b1, r ^ 5'd1, randData()};   // distinct rd, x0 now and then
            writeRegs(w1, w2);
            decode(1'b1, addInstr(w1.rd, w2.rd), addInstr(w2.rd, w1.rd));
        end
        writeRegs({1'b1, 5'd0, randData()}, '0);
        decode(1'b1, addInstr(5'd0, 5'd0), addInstr(5'd0, 5'd0));
        endTest("writeRead");

        repeat (6) begin
            r  = randReg() | 5'd1;
            w1 = {1'b1, r, randData()};
            w2 = {1'b1, r, randData()};
            writeRegs(w1, w2);
            decode(1'b1, addInstr(r, r), addInstr(r, 5'd0));
        end
        endTest("conflict");

        for (int k = 0; k < 70; k++) begin
            decode(1'b1, randInstr(k % 7), randInstr((k + 3) % 7));
        end
        endTest("decode");

        decode(1'b1, {20'($random(seed)), randReg(), `OP_JAL}, NOP);
        decode(1'b1, NOP, {12'($random(seed)), randReg(), 3'b000, randReg(), `OP_JALR});
        decode(1'b1, NOP, randInstr(6));
        decode(1'b1, randInstr(6), {20'($random(seed)), randReg(), `OP_JAL});
        decode(1'b1, ECALL, ECALL);
        decode(1'b1, NOP, NOP);
        endTest("flags");

        repeat (16) decode(1'b0, instrT'($random(seed)), instrT'($random(seed)));
        endTest("bubble");

        $display("tests run: %0d, tests failed: %0d, assertion failures: %0d",
                 testsRun, testsFailed, DUT.chk.failCount);
        if (DUT.chk.failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tests/rdWb_chk.sv ====
`timescale 1ns/1ps
`include "rdWb_consts.svh"

module rdWbChk import rdWbPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     enableD,
    input instrT    instrD1,
    input instrT    instrD2,
    input decCtrlT  ctrlD1,
    input decCtrlT  ctrlD2,
    input xlenT     immD1,
    input xlenT     immD2,
    input operandsT opsD1,
    input operandsT opsD2,
    input logic     jumpD,
    input logic     branchD,
    input logic     enableW,
    input wbReqT    wbW1,
    input wbReqT    wbW2
);

    int                 failCount = 0;   // read by the testbench
    xlenT               shadow [`NREGS];
    instrT    [1:0]     ins;
    decCtrlT  [1:0]     ctrl;
    xlenT     [1:0]     imm;
    operandsT [1:0]     ops;
    operandsT [1:0]     expOps;
    logic               expJump;
    logic               expBranch;
    logic               conflict;
    regIdxT             conflictRd;
    xlenT               conflictVal;

    assign ins  = {instrD2, instrD1};
    assign ctrl = {ctrlD2, ctrlD1};
    assign imm  = {immD2, immD1};
    assign ops  = {opsD2, opsD1};

    // add, sub, addi, ld, sd, lui and beq only
    function automatic logic covered(instrT i);
        case (i[6:0])
            `OP_REG:    return i[14:12] == 3'b000 && (i[31:25] == `F7_BASE || i[31:25] == `F7_ALT);
            `OP_IMM:    return i[14:12] == 3'b000;
            `OP_LOAD:   return i[14:12] == 3'b011;
            `OP_STORE:  return i[14:12] == 3'b011;
            `OP_LUI:    return 1'b1;
            `OP_BRANCH: return i[14:12] == 3'b000;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic decCtrlT expCtrl(instrT i);
        decCtrlT    c;
        logic [6:0] op;
        logic       noRd;
        op         = i[6:0];
        noRd       = op == `OP_STORE || op == `OP_BRANCH;
        c          = '0;
        c.rs1      = (op == `OP_LUI) ? 5'd0 : i[19:15];
        c.rs2      = (op == `OP_REG || noRd) ? i[24:20] : 5'd0;
        c.rd       = noRd ? 5'd0 : i[11:7];
        c.regWrite = !noRd;
        c.aluSrc   = !(op == `OP_REG || op == `OP_BRANCH);   // immediate as operand b
        c.resultSrc = (op == `OP_LOAD) ? `RES_MEM : `RES_ALU;
        if (op == `OP_LOAD) begin
            c.memSize = {`MEM_READ, i[14:12]};
        end else if (op == `OP_STORE) begin
            c.memSize = {`MEM_WRITE, i[14:12]};
        end
        if (op == `OP_LUI) begin
            c.aluCtrl = `ALU_LUI;
        end else if (op == `OP_BRANCH) begin
            c.aluCtrl = `ALU_BEQ;
        end else begin
            c.aluCtrl = (op == `OP_REG && i[30]) ? `ALU_SUB : `ALU_ADD;
        end
        return c;
    endfunction

    // sign extension comes from the signed cast
    function automatic xlenT expImm(instrT i);
        case (i[6:0])
            `OP_LOAD, `OP_IMM: return xlenT'($signed(i[31:20]));
            `OP_STORE:         return xlenT'($signed({i[31:25], i[11:7]}));
            `OP_BRANCH:        return xlenT'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
            `OP_LUI:           return xlenT'($signed({i[31:12], 12'h000}));
            default:           return '0;
        endcase
    endfunction

    function automatic logic isJump(instrT i);
        return i[6:0] == `OP_JAL || i[6:0] == `OP_JALR;
    endfunction

    // reference copy of the registers, lane 2 written last
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < `NREGS; r++) begin
                shadow[r] <= '0;
            end
            conflict <= 1'b0;
        end else begin
            if (enableW && wbW1.regWrite && wbW1.rd != '0) begin
                shadow[wbW1.rd] <= wbW1.result;
            end
            if (enableW && wbW2.regWrite && wbW2.rd != '0) begin
                shadow[wbW2.rd] <= wbW2.result;
            end
            conflict    <= enableW && wbW1.regWrite && wbW2.regWrite
                           && wbW1.rd == wbW2.rd && wbW1.rd != '0;
            conflictRd  <= wbW2.rd;
            conflictVal <= wbW2.result;
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            expOps[l] = {shadow[ctrl[l].rs1], shadow[ctrl[l].rs2]};
        end
    end

    assign expJump   = enableD && (isJump(instrD1) || isJump(instrD2));
    assign expBranch = enableD && (instrD1[6:0] == `OP_BRANCH || instrD2[6:0] == `OP_BRANCH);

    for (genvar l = 0; l < 2; l++) begin : laneChk
        ctrlOk: assert property (@(posedge clk) disable iff (!arstN)
            enableD && covered(ins[l]) |-> ctrl[l] == expCtrl(ins[l]))
            else begin
                failCount++;
                $error("MISMATCH t=%0t ctrlD%0d exp=%h got=%h", $time, l + 1,
                       expCtrl($sampled(ins[l])), $sampled(ctrl[l]));
            end
        immOk: assert property (@(posedge clk) disable iff (!arstN)
            enableD && covered(ins[l]) |-> imm[l] == expImm(ins[l]))
            else begin
                failCount++;
                $error("MISMATCH t=%0t immD%0d exp=%h got=%h", $time, l + 1,
                       expImm($sampled(ins[l])), $sampled(imm[l]));
            end
        opsOk: assert property (@(posedge clk) disable iff (!arstN) ops[l] == expOps[l])
            else begin
                failCount++;
                $error("MISMATCH t=%0t opsD%0d exp=%h got=%h", $time, l + 1,
                       $sampled(expOps[l]), $sampled(ops[l]));
            end
        ecallOk: assert property (@(posedge clk) disable iff (!arstN)
            enableD && ins[l] == 32'h0000_0073 |-> ctrl[l].ecall && ctrl[l].aluCtrl == `ALU_ECALL)
            else begin
                failCount++;
                $error("MISMATCH t=%0t ctrlD%0d.aluCtrl exp=%0d got=%0d", $time, l + 1,
                       `ALU_ECALL, $sampled(ctrl[l].aluCtrl));
            end
        bubbleOk: assert property (@(posedge clk) disable iff (!arstN)
            !enableD |-> ctrl[l] == '0 && imm[l] == '0 && ops[l] == '0 && !jumpD && !branchD)
            else begin
                failCount++;
                $error("MISMATCH t=%0t lane%0d outputs exp=0 got ctrl=%h imm=%h ops=%h", $time,
                       l + 1, $sampled(ctrl[l]), $sampled(imm[l]), $sampled(ops[l]));
            end
    end

    jumpOk: assert property (@(posedge clk) disable iff (!arstN) jumpD == expJump)
        else begin
            failCount++;
            $error("MISMATCH t=%0t jumpD exp=%b got=%b", $time, $sampled(expJump),
                   $sampled(jumpD));
        end

    branchOk: assert property (@(posedge clk) disable iff (!arstN) branchD == expBranch)
        else begin
            failCount++;
            $error("MISMATCH t=%0t branchD exp=%b got=%b", $time, $sampled(expBranch),
                   $sampled(branchD));
        end

    // shared rd keeps the lane 2 result
    conflictOk: assert property (@(posedge clk) disable iff (!arstN)
        conflict && ctrlD1.rs1 == conflictRd |-> opsD1.rs1Data == conflictVal)
        else begin
            failCount++;
            $error("MISMATCH t=%0t opsD1.rs1Data exp=%h got=%h", $time, $sampled(conflictVal),
                   $sampled(opsD1.rs1Data));
        end

endmodule
